// File: hw/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data path and address width
`define CORE_XLEN 32

`define CORE_INST_W 32

// Architectural register file
`define CORE_NUM_REGS 32
`define CORE_REG_ADDR_W 5

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// PC increment, one word, at full data width
`define CORE_PC_STEP {{(`CORE_XLEN-3){1'b0}}, 3'b100}

`endif

// File: hw/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic {
    ALU_A_RS1,
    ALU_A_PC
  } alu_a_sel_t;

  typedef enum logic {
    ALU_B_RS2,
    ALU_B_IMM
  } alu_b_sel_t;

  typedef enum logic [1:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_JUMP
  } br_op_t;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_sel_t;

  // Operand source for the EX stage
  typedef enum logic [1:0] {
    FWD_NONE,
    FWD_MEM,
    FWD_WB
  } fwd_src_t;

  typedef struct packed {
    alu_op_t                     alu_op;
    alu_a_sel_t                  alu_a_sel;
    alu_b_sel_t                  alu_b_sel;
    br_op_t                      br_op;
    wb_sel_t                     wb_sel;
    logic                        reg_we;
    logic                        load;
    logic                        store;
    logic [`CORE_REG_ADDR_W-1:0] rd;
    logic [`CORE_REG_ADDR_W-1:0] rs1;
    logic [`CORE_REG_ADDR_W-1:0] rs2;
  } ctrl_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_INST_W-1:0] inst;
  } if_id_t;

  typedef struct packed {
    ctrl_t                 ctrl;
    logic [`CORE_XLEN-1:0] rs1_val;
    logic [`CORE_XLEN-1:0] rs2_val;
    logic [`CORE_XLEN-1:0] imm;
    logic [`CORE_XLEN-1:0] pc;
  } id_ex_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0]       alu_result;
    logic [`CORE_XLEN-1:0]       store_data;
    logic [`CORE_XLEN-1:0]       pc4;
    wb_sel_t                     wb_sel;
    logic                        reg_we;
    logic                        load;
    logic                        store;
    logic [`CORE_REG_ADDR_W-1:0] rd;
  } ex_mem_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0]       result;
    logic                        reg_we;
    logic [`CORE_REG_ADDR_W-1:0] rd;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module fetch_unit (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_stall,
  input  wire logic                  i_redirect,
  input  wire logic [`CORE_XLEN-1:0] i_target,
  output logic      [`CORE_XLEN-1:0] o_pc
);

  // A redirect from EX takes priority over a load-use hold
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_pc <= `CORE_RESET_PC;
    end else if (i_redirect) begin
      o_pc <= i_target;
    end else if (!i_stall) begin
      o_pc <= o_pc + `CORE_PC_STEP;
    end
  end

endmodule

`default_nettype wire

// File: hw/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module instr_decoder
  import core_pkg::*;
(
  input  wire logic [`CORE_INST_W-1:0] i_inst,
  output ctrl_t                        o_ctrl,
  output logic      [`CORE_XLEN-1:0]   o_imm
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  always_comb begin
    // Anything not matched below stays a no-op
    o_ctrl = '0;
    o_imm  = '0;
    case (opcode)
      OPC_LUI: begin
        o_ctrl.alu_op    = ALU_PASS_B;
        o_ctrl.alu_b_sel = ALU_B_IMM;
        o_ctrl.reg_we    = 1'b1;
        o_ctrl.rd        = i_inst[11:7];
        o_imm            = {i_inst[31:12], 12'b0};
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          o_ctrl.alu_b_sel = ALU_B_IMM;
          o_ctrl.reg_we    = 1'b1;
          o_ctrl.rd        = i_inst[11:7];
          o_ctrl.rs1       = i_inst[19:15];
          o_imm            = {{20{i_inst[31]}}, i_inst[31:20]};
        end
      end
      OPC_OP: begin
        o_ctrl.reg_we = 1'b1;
        o_ctrl.rd     = i_inst[11:7];
        o_ctrl.rs1    = i_inst[19:15];
        o_ctrl.rs2    = i_inst[24:20];
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: o_ctrl.alu_op = ALU_ADD;
          {7'b0100000, 3'b000}: o_ctrl.alu_op = ALU_SUB;
          {7'b0000000, 3'b111}: o_ctrl.alu_op = ALU_AND;
          {7'b0000000, 3'b110}: o_ctrl.alu_op = ALU_OR;
          {7'b0000000, 3'b100}: o_ctrl.alu_op = ALU_XOR;
          {7'b0000000, 3'b010}: o_ctrl.alu_op = ALU_SLT;
          default:              o_ctrl = '0;
        endcase
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          o_ctrl.alu_b_sel = ALU_B_IMM;
          o_ctrl.wb_sel    = WB_LOAD;
          o_ctrl.reg_we    = 1'b1;
          o_ctrl.load      = 1'b1;
          o_ctrl.rd        = i_inst[11:7];
          o_ctrl.rs1       = i_inst[19:15];
          o_imm            = {{20{i_inst[31]}}, i_inst[31:20]};
        end
      end
      OPC_STORE: begin
        if (funct3 == 3'b010) begin
          o_ctrl.alu_b_sel = ALU_B_IMM;
          o_ctrl.store     = 1'b1;
          o_ctrl.rs1       = i_inst[19:15];
          o_ctrl.rs2       = i_inst[24:20];
          o_imm            = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
        end
      end
      OPC_BRANCH: begin
        // ALU forms the target, the compare runs on rs1 and rs2
        if (funct3 == 3'b000 || funct3 == 3'b001) begin
          o_ctrl.br_op     = (funct3 == 3'b000) ? BR_EQ : BR_NE;
          o_ctrl.alu_a_sel = ALU_A_PC;
          o_ctrl.alu_b_sel = ALU_B_IMM;
          o_ctrl.rs1       = i_inst[19:15];
          o_ctrl.rs2       = i_inst[24:20];
          o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                   i_inst[11:8], 1'b0};
        end
      end
      OPC_JAL: begin
        o_ctrl.br_op     = BR_JUMP;
        o_ctrl.alu_a_sel = ALU_A_PC;
        o_ctrl.alu_b_sel = ALU_B_IMM;
        o_ctrl.wb_sel    = WB_PC4;
        o_ctrl.reg_we    = 1'b1;
        o_ctrl.rd        = i_inst[11:7];
        o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                 i_inst[30:21], 1'b0};
      end
      default: begin
        o_ctrl = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module register_file (
  input  wire logic                        i_clk,
  input  wire logic                        i_rst_n,
  input  wire logic                        i_we,
  input  wire logic [`CORE_REG_ADDR_W-1:0] i_waddr,
  input  wire logic [`CORE_REG_ADDR_W-1:0] i_rs1_addr,
  input  wire logic [`CORE_REG_ADDR_W-1:0] i_rs2_addr,
  input  wire logic [`CORE_XLEN-1:0]       i_wdata,
  output logic      [`CORE_XLEN-1:0]       o_rs1,
  output logic      [`CORE_XLEN-1:0]       o_rs2
);

  logic [`CORE_XLEN-1:0] regs [`CORE_NUM_REGS];

  // Entry 0 is never written
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // Bypass so ID sees the value WB writes in the same cycle
  function automatic logic [`CORE_XLEN-1:0] read_reg(
    input logic [`CORE_REG_ADDR_W-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end
    if (i_we && addr == i_waddr) begin
      return i_wdata;
    end
    return regs[addr];
  endfunction

  always_comb begin
    o_rs1 = read_reg(i_rs1_addr);
    o_rs2 = read_reg(i_rs2_addr);
  end

  a_x0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n) regs[0] == '0)
    else $error("register x0 holds %h", regs[0]);

endmodule

`default_nettype wire

// File: hw/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type T = logic
) (
  input  wire logic i_clk,
  input  wire logic i_rst_n,
  input  wire logic i_stall,
  input  wire logic i_flush,
  input  wire logic i_valid,
  input  wire T     i_data,
  output logic      o_valid,
  output T          o_data
);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n || i_flush) begin
      o_valid <= 1'b0;
    end else if (!i_stall) begin
      o_valid <= i_valid;
    end
  end

  // Payload follows i_data unless stalled
  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_data <= i_data;
    end
  end

  a_no_stall_flush: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) !(i_stall && i_flush)
  ) else $error("stage register stalled and flushed together");

endmodule

`default_nettype wire

// File: hw/execute_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module execute_unit
  import core_pkg::*;
(
  input  wire logic                  i_valid,
  input  wire id_ex_t                i_data,
  input  wire fwd_src_t              i_fwd_a,
  input  wire fwd_src_t              i_fwd_b,
  input  wire logic [`CORE_XLEN-1:0] i_mem_result,
  input  wire logic [`CORE_XLEN-1:0] i_wb_result,
  output ex_mem_t                    o_data,
  output logic                       o_redirect,
  output logic      [`CORE_XLEN-1:0] o_target
);

  logic [`CORE_XLEN-1:0] rs1_fwd;
  logic [`CORE_XLEN-1:0] rs2_fwd;
  logic [`CORE_XLEN-1:0] alu_a;
  logic [`CORE_XLEN-1:0] alu_b;
  logic [`CORE_XLEN-1:0] alu_result;
  logic                  taken;

  function automatic logic [`CORE_XLEN-1:0] pick(
    input fwd_src_t              sel,
    input logic [`CORE_XLEN-1:0] reg_val
  );
    case (sel)
      FWD_MEM: return i_mem_result;
      FWD_WB:  return i_wb_result;
      default: return reg_val;
    endcase
  endfunction

  always_comb begin
    rs1_fwd = pick(i_fwd_a, i_data.rs1_val);
    rs2_fwd = pick(i_fwd_b, i_data.rs2_val);
    alu_a   = (i_data.ctrl.alu_a_sel == ALU_A_PC) ? i_data.pc : rs1_fwd;
    alu_b   = (i_data.ctrl.alu_b_sel == ALU_B_IMM) ? i_data.imm : rs2_fwd;

    alu_result = '0;
    case (i_data.ctrl.alu_op)
      ALU_SUB:    alu_result = alu_a - alu_b;
      ALU_AND:    alu_result = alu_a & alu_b;
      ALU_OR:     alu_result = alu_a | alu_b;
      ALU_XOR:    alu_result = alu_a ^ alu_b;
      ALU_SLT:    alu_result[0] = $signed(alu_a) < $signed(alu_b);
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = alu_a + alu_b;
    endcase

    case (i_data.ctrl.br_op)
      BR_EQ:   taken = (rs1_fwd == rs2_fwd);
      BR_NE:   taken = (rs1_fwd != rs2_fwd);
      BR_JUMP: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // Branches and JAL use the ALU as the PC plus offset adder
  assign o_redirect = i_valid && taken;
  assign o_target   = alu_result;

  always_comb begin
    o_data.alu_result = alu_result;
    o_data.store_data = rs2_fwd;
    o_data.pc4        = i_data.pc + `CORE_PC_STEP;
    o_data.wb_sel     = i_data.ctrl.wb_sel;
    o_data.reg_we     = i_data.ctrl.reg_we;
    o_data.load       = i_data.ctrl.load;
    o_data.store      = i_data.ctrl.store;
    o_data.rd         = i_data.ctrl.rd;
  end

endmodule

`default_nettype wire

// File: hw/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module hazard_unit
  import core_pkg::*;
(
  input  wire logic [`CORE_REG_ADDR_W-1:0] i_id_rs1,
  input  wire logic [`CORE_REG_ADDR_W-1:0] i_id_rs2,
  input  wire logic [`CORE_REG_ADDR_W-1:0] i_ex_rs1,
  input  wire logic [`CORE_REG_ADDR_W-1:0] i_ex_rs2,
  input  wire logic [`CORE_REG_ADDR_W-1:0] i_ex_rd,
  input  wire logic [`CORE_REG_ADDR_W-1:0] i_mem_rd,
  input  wire logic [`CORE_REG_ADDR_W-1:0] i_wb_rd,
  input  wire logic                        i_ex_load,
  input  wire logic                        i_ex_valid,
  input  wire logic                        i_mem_we,
  input  wire logic                        i_mem_valid,
  input  wire logic                        i_wb_we,
  input  wire logic                        i_wb_valid,
  input  wire logic                        i_redirect,
  output fwd_src_t                         o_fwd_a,
  output fwd_src_t                         o_fwd_b,
  output logic                             o_stall,
  output logic                             o_bubble,
  output logic                             o_flush
);

  logic load_use;

  // Youngest producer wins
  function automatic fwd_src_t fwd_sel(input logic [`CORE_REG_ADDR_W-1:0] rs);
    if (rs == '0) begin
      return FWD_NONE;
    end
    if (i_mem_valid && i_mem_we && rs == i_mem_rd) begin
      return FWD_MEM;
    end
    if (i_wb_valid && i_wb_we && rs == i_wb_rd) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  always_comb begin
    o_fwd_a = fwd_sel(i_ex_rs1);
    o_fwd_b = fwd_sel(i_ex_rs2);
  end

  // Load data only exists in MEM, so the consumer waits one cycle in ID
  assign load_use = i_ex_valid && i_ex_load && i_ex_rd != '0 &&
                    (i_ex_rd == i_id_rs1 || i_ex_rd == i_id_rs2);

  assign o_stall  = load_use;
  assign o_bubble = load_use;
  assign o_flush  = i_redirect;

  // A load in EX is never a branch, so hold and redirect cannot meet
  always_comb begin
    if (o_stall) begin
      assert final (!i_redirect)
        else $error("load-use stall during a redirect");
    end
  end

endmodule

`default_nettype wire

// File: hw/mem_access.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module mem_access
  import core_pkg::*;
(
  input  wire logic                  i_valid,
  input  wire ex_mem_t               i_data,
  input  wire logic [`CORE_XLEN-1:0] i_dmem_rdata,
  output logic      [`CORE_XLEN-1:0] o_dmem_addr,
  output logic      [`CORE_XLEN-1:0] o_dmem_wdata,
  output logic                       o_dmem_we,
  output logic      [`CORE_XLEN-1:0] o_result,
  output mem_wb_t                    o_wb_data
);

  assign o_dmem_addr  = i_data.alu_result;
  assign o_dmem_wdata = i_data.store_data;
  assign o_dmem_we    = i_valid && i_data.store;

  // Also the MEM forwarding value, load data included
  always_comb begin
    case (i_data.wb_sel)
      WB_LOAD: o_result = i_dmem_rdata;
      WB_PC4:  o_result = i_data.pc4;
      default: o_result = i_data.alu_result;
    endcase
  end

  always_comb begin
    o_wb_data.result = o_result;
    o_wb_data.reg_we = i_data.reg_we;
    o_wb_data.rd     = i_data.rd;
  end

  // Word accesses only
  always_comb begin
    if (i_valid && (i_data.load || i_data.store)) begin
      assert final (i_data.alu_result[1:0] == 2'b00)
        else $error("misaligned data access at %h", i_data.alu_result);
    end
  end

endmodule

`default_nettype wire

// File: hw/core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_top
  import core_pkg::*;
(
  input  wire logic                   i_clk,
  input  wire logic                   i_rst_n,
  output logic      [`CORE_XLEN-1:0]   o_imem_addr,
  input  wire logic [`CORE_INST_W-1:0] i_imem_rdata,
  output logic      [`CORE_XLEN-1:0]   o_dmem_addr,
  output logic      [`CORE_XLEN-1:0]   o_dmem_wdata,
  output logic                         o_dmem_we,
  input  wire logic [`CORE_XLEN-1:0]   i_dmem_rdata
);

  logic [`CORE_XLEN-1:0] if_pc;
  if_id_t                if_data;
  logic                  id_valid;
  if_id_t                id_data;
  ctrl_t                 id_ctrl;
  logic [`CORE_XLEN-1:0] id_imm;
  logic [`CORE_XLEN-1:0] id_rs1_val;
  logic [`CORE_XLEN-1:0] id_rs2_val;
  id_ex_t                id_ex_in;
  logic                  ex_valid;
  id_ex_t                ex_data;
  ex_mem_t               ex_out;
  logic                  ex_redirect;
  logic [`CORE_XLEN-1:0] ex_target;
  logic                  mem_valid;
  ex_mem_t               mem_data;
  logic [`CORE_XLEN-1:0] mem_result;
  mem_wb_t               mem_wb_in;
  logic                  wb_valid;
  mem_wb_t               wb_data;
  fwd_src_t              fwd_a;
  fwd_src_t              fwd_b;
  logic                  hz_stall;
  logic                  hz_bubble;
  logic                  hz_flush;

  assign o_imem_addr = if_pc;
  assign if_data     = '{pc: if_pc, inst: i_imem_rdata};
  assign id_ex_in    = '{ctrl: id_ctrl, rs1_val: id_rs1_val, rs2_val: id_rs2_val,
                         imm: id_imm, pc: id_data.pc};

  fetch_unit fetch0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_stall    (hz_stall),
    .i_redirect (ex_redirect),
    .i_target   (ex_target),
    .o_pc       (if_pc)
  );

  pipe_reg #(.T(if_id_t)) if_id (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_stall (hz_stall),
    .i_flush (hz_flush),
    .i_valid (1'b1),
    .i_data  (if_data),
    .o_valid (id_valid),
    .o_data  (id_data)
  );

  instr_decoder dec0 (
    .i_inst (id_data.inst),
    .o_ctrl (id_ctrl),
    .o_imm  (id_imm)
  );

  // Written from WB, read in ID
  register_file rf0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_we       (wb_valid && wb_data.reg_we),
    .i_waddr    (wb_data.rd),
    .i_rs1_addr (id_ctrl.rs1),
    .i_rs2_addr (id_ctrl.rs2),
    .i_wdata    (wb_data.result),
    .o_rs1      (id_rs1_val),
    .o_rs2      (id_rs2_val)
  );

  pipe_reg #(.T(id_ex_t)) id_ex (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_stall (1'b0),
    .i_flush (hz_bubble || hz_flush),
    .i_valid (id_valid),
    .i_data  (id_ex_in),
    .o_valid (ex_valid),
    .o_data  (ex_data)
  );

  execute_unit ex0 (
    .i_valid      (ex_valid),
    .i_data       (ex_data),
    .i_fwd_a      (fwd_a),
    .i_fwd_b      (fwd_b),
    .i_mem_result (mem_result),
    .i_wb_result  (wb_data.result),
    .o_data       (ex_out),
    .o_redirect   (ex_redirect),
    .o_target     (ex_target)
  );

  pipe_reg #(.T(ex_mem_t)) ex_mem (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_stall (1'b0),
    .i_flush (1'b0),
    .i_valid (ex_valid),
    .i_data  (ex_out),
    .o_valid (mem_valid),
    .o_data  (mem_data)
  );

  mem_access mem0 (
    .i_valid      (mem_valid),
    .i_data       (mem_data),
    .i_dmem_rdata (i_dmem_rdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_result     (mem_result),
    .o_wb_data    (mem_wb_in)
  );

  pipe_reg #(.T(mem_wb_t)) mem_wb (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_stall (1'b0),
    .i_flush (1'b0),
    .i_valid (mem_valid),
    .i_data  (mem_wb_in),
    .o_valid (wb_valid),
    .o_data  (wb_data)
  );

  hazard_unit hz0 (
    .i_id_rs1    (id_ctrl.rs1),
    .i_id_rs2    (id_ctrl.rs2),
    .i_ex_rs1    (ex_data.ctrl.rs1),
    .i_ex_rs2    (ex_data.ctrl.rs2),
    .i_ex_rd     (ex_data.ctrl.rd),
    .i_mem_rd    (mem_data.rd),
    .i_wb_rd     (wb_data.rd),
    .i_ex_load   (ex_data.ctrl.load),
    .i_ex_valid  (ex_valid),
    .i_mem_we    (mem_data.reg_we),
    .i_mem_valid (mem_valid),
    .i_wb_we     (wb_data.reg_we),
    .i_wb_valid  (wb_valid),
    .i_redirect  (ex_redirect),
    .o_fwd_a     (fwd_a),
    .o_fwd_b     (fwd_b),
    .o_stall     (hz_stall),
    .o_bubble    (hz_bubble),
    .o_flush     (hz_flush)
  );

endmodule

`default_nettype wire

// File: testbench/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// RV32I encodings
function automatic logic [31:0] lui_inst(input logic [4:0] rd, input logic [19:0] imm);
  return {imm, rd, 7'b0110111};
endfunction

function automatic logic [31:0] addi_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
  return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

function automatic logic [31:0] rtype_inst(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] lw_inst(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
  return {imm, rs1, 3'b010, rd, 7'b0000011};
endfunction

function automatic logic [31:0] sw_inst(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

// f3 000 is BEQ, 001 is BNE
function automatic logic [31:0] branch_inst(input logic [2:0] f3, input logic [4:0] rs1,
                                            input logic [4:0] rs2, input logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] jal_inst(input logic [4:0] rd, input logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

task automatic alu_chain();
  logic [31:0] r1, r2, r3, r4, r5, r6, r7, r9, r10, r11, r12;
  prog.delete();
  emit(addi_inst(5'd1, 5'd0, 12'd100));
  emit(addi_inst(5'd2, 5'd1, -12'sd37));
  emit(rtype_inst(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
  emit(sw_inst(5'd3, 5'd0, 12'h100));
  emit(rtype_inst(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
  emit(rtype_inst(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));
  emit(rtype_inst(7'h00, 3'b110, 5'd6, 5'd5, 5'd2));
  emit(rtype_inst(7'h00, 3'b100, 5'd7, 5'd6, 5'd4));
  emit(sw_inst(5'd4, 5'd0, 12'h104));
  emit(sw_inst(5'd5, 5'd0, 12'h108));
  emit(sw_inst(5'd6, 5'd0, 12'h10c));
  emit(sw_inst(5'd7, 5'd0, 12'h110));
  emit(addi_inst(5'd9, 5'd0, -12'sd5));
  emit(rtype_inst(7'h00, 3'b010, 5'd10, 5'd9, 5'd1));
  emit(rtype_inst(7'h00, 3'b010, 5'd11, 5'd1, 5'd9));
  emit(sw_inst(5'd10, 5'd0, 12'h114));
  emit(sw_inst(5'd11, 5'd0, 12'h118));
  emit(lui_inst(5'd12, 20'habcde));
  emit(addi_inst(5'd12, 5'd12, 12'h123));
  emit(sw_inst(5'd12, 5'd0, 12'h11c));
  emit(jal_inst(5'd0, 21'd0));
  r1  = 32'd100;
  r2  = r1 - 32'd37;
  r3  = r1 + r2;
  r4  = r3 - r1;
  r5  = r4 & r3;
  r6  = r5 | r2;
  r7  = r6 ^ r4;
  r9  = 32'd0 - 32'd5;
  r10 = ($signed(r9) < $signed(r1)) ? 32'd1 : 32'd0;
  r11 = ($signed(r1) < $signed(r9)) ? 32'd1 : 32'd0;
  r12 = {20'habcde, 12'h000} + 32'h123;
  reset_and_load();
  wait_store(32'h100, r3, "add x3");
  wait_store(32'h104, r4, "sub x4");
  wait_store(32'h108, r5, "and x5");
  wait_store(32'h10c, r6, "or x6");
  wait_store(32'h110, r7, "xor x7");
  wait_store(32'h114, r10, "slt x10");
  wait_store(32'h118, r11, "slt x11");
  wait_store(32'h11c, r12, "lui x12");
  expect_quiet("the ALU chain");
endtask

task automatic load_then_use();
  logic [31:0] v;
  prog.delete();
  emit(lui_inst(5'd1, 20'h12345));
  emit(addi_inst(5'd1, 5'd1, 12'h678));
  emit(addi_inst(5'd4, 5'd0, 12'd77));
  emit(sw_inst(5'd1, 5'd0, 12'h140));
  emit(lw_inst(5'd2, 5'd0, 12'h140));
  emit(rtype_inst(7'h00, 3'b000, 5'd3, 5'd2, 5'd4));
  emit(sw_inst(5'd3, 5'd0, 12'h144));
  emit(lw_inst(5'd5, 5'd0, 12'h144));
  emit(sw_inst(5'd5, 5'd0, 12'h148));
  emit(jal_inst(5'd0, 21'd0));
  v = 32'h1234_5678;
  reset_and_load();
  wait_store(32'h140, v, "the original value");
  wait_store(32'h144, v + 32'd77, "the loaded value plus 77");
  wait_store(32'h148, v + 32'd77, "the value loaded and stored back");
  expect_quiet("the load-use program");
endtask

task automatic branch_paths();
  logic [31:0] r1, r2, r3;
  prog.delete();
  emit(addi_inst(5'd1, 5'd0, 12'd5));
  emit(addi_inst(5'd3, 5'd0, 12'd7));
  emit(addi_inst(5'd2, 5'd0, 12'd5));
  emit(branch_inst(3'b000, 5'd1, 5'd2, 13'd12));
  emit(sw_inst(5'd1, 5'd0, 12'h180));
  emit(sw_inst(5'd2, 5'd0, 12'h184));
  emit(sw_inst(5'd3, 5'd0, 12'h188));
  emit(branch_inst(3'b001, 5'd1, 5'd2, 13'd12));
  emit(sw_inst(5'd1, 5'd0, 12'h18c));
  emit(sw_inst(5'd2, 5'd0, 12'h190));
  emit(branch_inst(3'b001, 5'd1, 5'd3, 13'd12));
  emit(sw_inst(5'd3, 5'd0, 12'h194));
  emit(sw_inst(5'd3, 5'd0, 12'h198));
  emit(branch_inst(3'b000, 5'd1, 5'd3, 13'd12));
  emit(sw_inst(5'd1, 5'd0, 12'h19c));
  emit(sw_inst(5'd3, 5'd0, 12'h1a0));
  emit(jal_inst(5'd0, 21'd0));
  r1 = 32'd5;
  r2 = 32'd5;
  r3 = 32'd7;
  reset_and_load();
  // A taken branch skips the two stores behind it
  if (r1 != r2) begin
    wait_store(32'h180, r1, "the store after the first BEQ");
    wait_store(32'h184, r2, "the second store after the first BEQ");
  end
  wait_store(32'h188, r3, "the first BEQ target");
  if (r1 == r2) begin
    wait_store(32'h18c, r1, "the store after the first BNE");
    wait_store(32'h190, r2, "the second store after the first BNE");
  end
  if (r1 == r3) begin
    wait_store(32'h194, r3, "the store after the second BNE");
    wait_store(32'h198, r3, "the second store after the second BNE");
  end
  if (r1 != r3) begin
    wait_store(32'h19c, r1, "the store after the second BEQ");
    wait_store(32'h1a0, r3, "the second store after the second BEQ");
  end
  expect_quiet("the branch program");
endtask

task automatic jump_and_link();
  prog.delete();
  emit(addi_inst(5'd1, 5'd0, 12'd9));
  emit(jal_inst(5'd5, 21'd12));
  emit(sw_inst(5'd1, 5'd0, 12'h1c0));
  emit(sw_inst(5'd1, 5'd0, 12'h1c4));
  emit(sw_inst(5'd5, 5'd0, 12'h1c8));
  emit(jal_inst(5'd6, 21'd8));
  emit(sw_inst(5'd1, 5'd0, 12'h1cc));
  emit(sw_inst(5'd6, 5'd0, 12'h1d0));
  emit(sw_inst(5'd1, 5'd0, 12'h1d4));
  emit(jal_inst(5'd0, 21'd0));
  reset_and_load();
  // Link is the JAL address plus 4
  wait_store(32'h1c8, 32'h4 + 32'h4, "the link of the first JAL");
  wait_store(32'h1d0, 32'h14 + 32'h4, "the link of the second JAL");
  wait_store(32'h1d4, 32'd9, "x1 after both jumps");
  expect_quiet("the JAL program");
endtask

task automatic random_arith();
  logic [31:0] a [4];
  logic [31:0] b [4];
  logic [11:0] base;
  prog.delete();
  base = 12'h200;
  for (int k = 0; k < 4; k++) begin
    draw_word(a[k]);
    draw_word(b[k]);
    // ADDI sign-extends, so the upper part absorbs bit 11
    emit(lui_inst(5'd1, a[k][31:12] + {19'b0, a[k][11]}));
    emit(addi_inst(5'd1, 5'd1, a[k][11:0]));
    emit(lui_inst(5'd2, b[k][31:12] + {19'b0, b[k][11]}));
    emit(addi_inst(5'd2, 5'd2, b[k][11:0]));
    emit(rtype_inst(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    emit(rtype_inst(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
    emit(rtype_inst(7'h00, 3'b100, 5'd5, 5'd1, 5'd2));
    emit(sw_inst(5'd1, 5'd0, base));
    emit(sw_inst(5'd3, 5'd0, base + 12'h4));
    emit(sw_inst(5'd4, 5'd0, base + 12'h8));
    emit(sw_inst(5'd5, 5'd0, base + 12'hc));
    base = base + 12'h020;
  end
  emit(jal_inst(5'd0, 21'd0));
  reset_and_load();
  base = 12'h200;
  for (int k = 0; k < 4; k++) begin
    wait_store({20'b0, base}, a[k], $sformatf("random value %0d", k));
    wait_store({20'b0, base + 12'h4}, a[k] + b[k], $sformatf("random sum %0d", k));
    wait_store({20'b0, base + 12'h8}, a[k] - b[k], $sformatf("random difference %0d", k));
    wait_store({20'b0, base + 12'hc}, a[k] ^ b[k], $sformatf("random xor %0d", k));
    base = base + 12'h020;
  end
  expect_quiet("the random operand program");
endtask

`endif

// File: testbench/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;

  localparam int          CLK_HALF      = 20;
  localparam int          RESET_CYCLES  = 5;
  localparam int          MEM_WORDS     = 256;
  localparam int          STORE_TIMEOUT = 200;
  localparam int          QUIET_CYCLES  = 30;
  localparam logic [31:0] RESET_PC      = 32'h0000_0000;
  // ADDI x0, x0, 0
  localparam logic [31:0] NOP           = 32'h0000_0013;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic [31:0] dmem_rdata;

  logic [31:0] imem [MEM_WORDS];
  logic [31:0] dmem [MEM_WORDS];
  logic [31:0] prog [$];
  logic [31:0] st_addr_q [$];
  logic [31:0] st_data_q [$];
  logic [31:0] lfsr;

  core_top dut0 (
    .i_clk        (clk),
    .i_rst_n      (rst_n),
    .o_imem_addr  (imem_addr),
    .i_imem_rdata (imem_rdata),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .i_dmem_rdata (dmem_rdata)
  );

  initial begin
    clk = 1'b0;
  end

  always #CLK_HALF clk = ~clk;

  // Both memories answer in the same cycle
  assign imem_rdata = imem[imem_addr[9:2]];
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  // Store strobes are taken mid-cycle, when the MEM stage outputs are settled
  always @(negedge clk) begin
    if (dmem_we === 1'b1) begin
      st_addr_q.push_back(dmem_addr);
      st_data_q.push_back(dmem_wdata);
      dmem[dmem_addr[9:2]] = dmem_wdata;
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0d ns: %s got %h expected %h",
                         $time, name, got, exp));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic draw_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w    = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // Program goes in while reset holds the core, so nothing runs half loaded
  task automatic reset_and_load();
    @(posedge clk);
    rst_n <= 1'b0;
    for (int c = 0; c < RESET_CYCLES - 1; c++) begin
      @(posedge clk);
      if (c == 0) begin
        for (int i = 0; i < MEM_WORDS; i++) begin
          imem[i] = (i < prog.size()) ? prog[i] : NOP;
          dmem[i] = (i << 2) ^ 32'hc3a5_0000;
        end
        st_addr_q.delete();
        st_data_q.delete();
      end
      @(negedge clk);
      check_value("o_dmem_we", {31'b0, dmem_we}, 32'h0);
    end
    @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("o_imem_addr", imem_addr, RESET_PC);
    check_value("o_dmem_we", {31'b0, dmem_we}, 32'h0);
  endtask

  task automatic wait_store(input logic [31:0] exp_addr, input logic [31:0] exp_data,
                            input string what);
    int cycles;
    cycles = 0;
    while (st_addr_q.size() == 0 && cycles < STORE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (st_addr_q.size() == 0) begin
      fail_run($sformatf("Timeout: the store of %s never came within %0d cycles",
                         what, STORE_TIMEOUT));
    end else begin
      check_value({"o_dmem_addr for ", what}, st_addr_q.pop_front(), exp_addr);
      check_value({"o_dmem_wdata for ", what}, st_data_q.pop_front(), exp_data);
    end
  endtask

  // The program ends in a self loop, so nothing more may be stored
  task automatic expect_quiet(input string what);
    repeat (QUIET_CYCLES) @(posedge clk);
    check_value({"extra store count after ", what}, st_addr_q.size(), 32'd0);
  endtask

  `include "tb_programs.svh"

  initial begin
    rst_n = 1'b0;
    lfsr  = 32'h992f;
    prog.delete();
    alu_chain();
    load_then_use();
    branch_paths();
    jump_and_link();
    random_arith();
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
+incdir+hw
+incdir+testbench
hw/core_pkg.sv
hw/fetch_unit.sv
hw/instr_decoder.sv
hw/register_file.sv
hw/pipe_reg.sv
hw/execute_unit.sv
hw/hazard_unit.sv
hw/mem_access.sv
hw/core_top.sv
testbench/tb_core.sv
